//--- Makefile
# Verilator flow for the APB calculator
# Override on the command line, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_calc
RTL_TOP   ?= calc_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Exit status is nonzero when the testbench stops with $fatal
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- calc_alu.sv
/* ALU stage between the command and result FIFOs; pops one command per
   cycle, registers its result and pushes it on the next cycle */
module calc_alu import calc_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  // Command FIFO pop side
  input  calc_cmd_t cmd_data,
  input  logic      cmd_empty,
  output logic      cmd_pop,
  // Result FIFO push side
  output calc_res_t res_data,
  input  logic      res_full,
  output logic      res_push
);

  calc_res_t   res_c;   // Combinational result of the head command
  calc_res_t   res_q;   // Output register
  logic        valid_q;
  logic        drain;   // Output register empties this cycle
  logic [8:0]  wide;    // Add and subtract with carry or borrow
  logic [15:0] prod;    // Full product

  assign drain    = valid_q && !res_full;
  assign res_push = drain;
  assign res_data = res_q;

  // Take the next command while the current result leaves
  assign cmd_pop = !cmd_empty && (!valid_q || drain);

  always_comb begin
    wide  = '0;
    prod  = '0;
    res_c = '0;
    case (cmd_data.opcode)
      op_add: begin
        wide  = {1'b0, cmd_data.in1} + {1'b0, cmd_data.in2};
        res_c = calc_res_t'(wide); // Carry lands in overflow
      end
      op_sub: begin
        wide  = {1'b0, cmd_data.in1} - {1'b0, cmd_data.in2};
        res_c = calc_res_t'(wide); // Bit 8 set on borrow
      end
      op_mul: begin
        prod           = 16'(cmd_data.in1) * 16'(cmd_data.in2);
        res_c.result   = prod[7:0];
        res_c.overflow = |prod[15:8]; // True product above 255
      end
      op_div: begin
        if (cmd_data.in2 == 8'd0) begin
          res_c.overflow = 1'b1; // Divide by zero, result stays 0
        end else begin
          res_c.result = cmd_data.in1 / cmd_data.in2;
        end
      end
      default: res_c = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (cmd_pop) begin
      valid_q <= 1'b1; // Refill, possibly while draining
    end else if (drain) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_pop) begin
      res_q <= res_c;
    end
  end

endmodule

//--- calc_alu_sva.sv
/* Checker bound into every calc_alu; golden model at pop, compare at push,
   X checks on the handshake and coverage of opcodes and corner operands */
module calc_alu_sva import calc_pkg::*; (
  input logic      clk,
  input logic      rst_n,
  input calc_cmd_t cmd_data,
  input logic      cmd_pop,
  input calc_res_t res_data,
  input logic      res_push
);

  calc_res_t   exp_c;
  calc_res_t   exp_q; // Expected value of the result in flight
  logic [16:0] full_w;

  // Reference arithmetic in plain wide math
  always_comb begin
    full_w = '0;
    exp_c  = '0;
    case (cmd_data.opcode)
      op_add: begin
        full_w         = 17'(cmd_data.in1) + 17'(cmd_data.in2);
        exp_c.result   = full_w[7:0];
        exp_c.overflow = (full_w > 17'd255);
      end
      op_sub: begin
        exp_c.result   = cmd_data.in1 - cmd_data.in2;
        exp_c.overflow = (cmd_data.in1 < cmd_data.in2); // Borrow
      end
      op_mul: begin
        full_w         = 17'(cmd_data.in1) * 17'(cmd_data.in2);
        exp_c.result   = full_w[7:0];
        exp_c.overflow = (full_w > 17'd255);
      end
      default: begin
        exp_c.overflow = (cmd_data.in2 == 8'd0);
        exp_c.result   = exp_c.overflow ? 8'd0 : cmd_data.in1 / cmd_data.in2;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (cmd_pop) begin
      exp_q <= exp_c;
    end
  end

  a_result : assert property (@(posedge clk) disable iff (!rst_n)
    res_push |-> res_data == exp_q)
    else $error("ALU got %h exp %h", res_data, exp_q);

  a_no_x_strobe : assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown({cmd_pop, res_push}))
    else $error("ALU strobe is X");

  a_no_x_data : assert property (@(posedge clk) disable iff (!rst_n)
    res_push |-> !$isunknown(res_data))
    else $error("ALU result is X");

  // Coverage, sampled at pop
  c_add     : cover property (@(posedge clk) cmd_pop && cmd_data.opcode == op_add);
  c_sub     : cover property (@(posedge clk) cmd_pop && cmd_data.opcode == op_sub);
  c_mul     : cover property (@(posedge clk) cmd_pop && cmd_data.opcode == op_mul);
  c_div     : cover property (@(posedge clk) cmd_pop && cmd_data.opcode == op_div);
  c_carry   : cover property (@(posedge clk)
    cmd_pop && cmd_data.opcode == op_add && exp_c.overflow);
  c_borrow  : cover property (@(posedge clk)
    cmd_pop && cmd_data.opcode == op_sub && exp_c.overflow);
  c_mul_ovf : cover property (@(posedge clk)
    cmd_pop && cmd_data.opcode == op_mul && exp_c.overflow);
  c_div0    : cover property (@(posedge clk)
    cmd_pop && cmd_data.opcode == op_div && cmd_data.in2 == 8'd0);
  c_in1_min : cover property (@(posedge clk) cmd_pop && cmd_data.in1 == 8'h00);
  c_in1_max : cover property (@(posedge clk) cmd_pop && cmd_data.in1 == 8'hff);
  c_in2_max : cover property (@(posedge clk) cmd_pop && cmd_data.in2 == 8'hff);

endmodule

bind calc_alu calc_alu_sva u_alu_sva (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_data (cmd_data),
  .cmd_pop  (cmd_pop),
  .res_data (res_data),
  .res_push (res_push)
);

//--- calc_apb_regs.sv
/* APB slave front end; writes push commands, reads return status or pop
   results, and a write to a full command FIFO stalls the bus */
module calc_apb_regs import calc_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  // APB
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [apb_aw-1:0] paddr,
  input  logic [apb_dw-1:0] pwdata,
  output logic [apb_dw-1:0] prdata,
  output logic              pready,
  output logic              pslverr,
  // Command FIFO push side
  output logic              cmd_push,
  output calc_cmd_t         cmd_data,
  input  logic              cmd_full,
  // Result FIFO pop side
  output logic              res_pop,
  input  calc_res_t         res_data,
  input  logic              res_empty,
  input  logic [cnt_w-1:0]  res_count
);

  logic access;    // Access phase
  logic wr_cmd;    // Write to the command register
  logic rd_status;
  logic rd_result;
  logic stall;     // Command write held off by a full FIFO
  logic done;      // Transfer completes this cycle

  assign access    = psel && penable;
  assign wr_cmd    = access && pwrite && (paddr == addr_cmd);
  assign rd_status = access && !pwrite && (paddr == addr_status);
  assign rd_result = access && !pwrite && (paddr == addr_result);

  assign stall  = wr_cmd && cmd_full;
  assign pready = access && !stall; // Low when idle
  assign done   = access && pready;

  // One-cycle strobes at completion
  assign cmd_push = wr_cmd && !cmd_full;
  assign res_pop  = rd_result && !res_empty; // Empty read pops nothing

  // Command fields line up with pwdata bit positions
  assign cmd_data = calc_cmd_t'(pwdata[$bits(calc_cmd_t)-1:0]);

  // Read mux
  always_comb begin
    prdata = '0;
    if (rd_status) begin
      prdata[0]   = cmd_full;
      prdata[1]   = res_empty;
      prdata[7:4] = 4'(res_count); // Result occupancy
    end else if (rd_result && !res_empty) begin
      prdata[$bits(calc_res_t)-1:0] = res_data; // Result and overflow
    end
  end

  // Error response
  always_comb begin
    pslverr = 1'b0;
    if (done) begin
      if (pwrite) begin
        pslverr = (paddr != addr_cmd); // Only the command register is writable
      end else begin
        // Unmapped read, or result read with nothing queued
        pslverr = !(rd_status || rd_result) || (rd_result && res_empty);
      end
    end
  end

  a_penable_psel : assert property (@(posedge clk) disable iff (!rst_n)
    penable |-> psel)
    else $error("APB penable high without psel");

  // Host keeps a stalled write on the bus unchanged
  a_stall_hold : assert property (@(posedge clk) disable iff (!rst_n)
    stall |=> access && pwrite && $stable(paddr) && $stable(pwdata))
    else $error("APB stalled write dropped or changed");

endmodule

//--- calc_fifo.sv
/* Synchronous FIFO with a type parameter for the payload; the calculator
   uses one for commands and one for results */
module calc_fifo import calc_pkg::*; #(
  parameter type payload_t = logic
) (
  input  logic             clk,
  input  logic             rst_n,
  // Push side
  input  logic             push,
  input  payload_t         push_data,
  output logic             full,
  // Pop side, head visible without a pop
  input  logic             pop,
  output payload_t         pop_data,
  output logic             empty,
  output logic [cnt_w-1:0] count
);

  payload_t         mem [fifo_depth]; // Storage, no reset needed
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count_q;

  assign full     = (count_q == cnt_w'(fifo_depth));
  assign empty    = (count_q == '0);
  assign count    = count_q;
  assign pop_data = mem[rd_ptr]; // Head entry, combinational

  // Payload write
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1; // Wraps at depth
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // Idle or push and pop together
      endcase
    end
  end

  // Producer must respect full, consumer must respect empty
  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
    !(push && full))
    else $error("FIFO push while full");

  a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
    !(pop && empty))
    else $error("FIFO pop while empty");

endmodule

//--- calc_pkg.sv
/* Shared types and constants for the APB calculator: opcodes, register map,
   FIFO sizing and the command and result payloads */
package calc_pkg;

  // APB geometry
  localparam int apb_aw = 4;
  localparam int apb_dw = 32;

  // Register map, byte addresses
  localparam logic [apb_aw-1:0] addr_cmd    = 4'h0; // Write pushes a command
  localparam logic [apb_aw-1:0] addr_status = 4'h4; // Status word, read only
  localparam logic [apb_aw-1:0] addr_result = 4'h8; // Read pops a result

  // Both FIFOs share one depth, power of two so pointers wrap on their own
  localparam int fifo_depth = 4;
  localparam int ptr_w      = $clog2(fifo_depth);
  localparam int cnt_w      = $clog2(fifo_depth) + 1; // Holds 0..fifo_depth

  typedef enum logic [1:0] {
    op_add = 2'd0,
    op_sub = 2'd1,
    op_mul = 2'd2,
    op_div = 2'd3
  } calc_op_e;

  // Field order matches pwdata: in1 [7:0], in2 [15:8], opcode [17:16]
  typedef struct packed {
    calc_op_e   opcode;
    logic [7:0] in2;
    logic [7:0] in1;
  } calc_cmd_t;

  // Matches prdata of a result read: overflow on bit 8
  typedef struct packed {
    logic       overflow; // Carry, borrow, product > 255 or divide by zero
    logic [7:0] result;
  } calc_res_t;

endpackage

//--- calc_top.sv
/* Calculator top level; APB front end feeding a command FIFO, the ALU stage
   and a result FIFO read back over the same bus */
module calc_top import calc_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [apb_aw-1:0] paddr,
  input  logic [apb_dw-1:0] pwdata,
  output logic [apb_dw-1:0] prdata,
  output logic              pready,
  output logic              pslverr
);

  // Command path
  logic             cmd_push;
  calc_cmd_t        cmd_wdata;
  logic             cmd_full;
  logic             cmd_pop;
  calc_cmd_t        cmd_rdata;
  logic             cmd_empty;
  // Result path
  logic             res_push;
  calc_res_t        res_wdata;
  logic             res_full;
  logic             res_pop;
  calc_res_t        res_rdata;
  logic             res_empty;
  logic [cnt_w-1:0] res_count; // Reported in status

  calc_apb_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .cmd_push  (cmd_push),
    .cmd_data  (cmd_wdata),
    .cmd_full  (cmd_full),
    .res_pop   (res_pop),
    .res_data  (res_rdata),
    .res_empty (res_empty),
    .res_count (res_count)
  );

  calc_fifo #(.payload_t(calc_cmd_t)) u_cmd_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (cmd_push),
    .push_data (cmd_wdata),
    .full      (cmd_full),
    .pop       (cmd_pop),
    .pop_data  (cmd_rdata),
    .empty     (cmd_empty),
    .count     ()          // Command occupancy not reported
  );

  calc_alu u_alu (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_data  (cmd_rdata),
    .cmd_empty (cmd_empty),
    .cmd_pop   (cmd_pop),
    .res_data  (res_wdata),
    .res_full  (res_full),
    .res_push  (res_push)
  );

  calc_fifo #(.payload_t(calc_res_t)) u_res_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (res_push),
    .push_data (res_wdata),
    .full      (res_full),
    .pop       (res_pop),
    .pop_data  (res_rdata),
    .empty     (res_empty),
    .count     (res_count)
  );

endmodule

//--- src.f
calc_pkg.sv
calc_fifo.sv
calc_apb_regs.sv
calc_alu.sv
calc_alu_sva.sv
calc_top.sv
tb_calc.sv

//--- tb_calc.sv
/* Testbench for the APB calculator; drives commands and reads over APB while
   concurrent assertions check every response against a reference queue */
module tb_calc import calc_pkg::*; ();

  localparam int max_stored     = 2 * fifo_depth + 1; // Both FIFOs plus the ALU register
  localparam int n_random       = 60;
  localparam int test_cycles    = 500;                // Rough length of all phases
  localparam int timeout_cycles = 4 * test_cycles;
  localparam int stall_cycles   = 8;                  // How long a stalled write is watched
  localparam logic [apb_aw-1:0] addr_unmapped = 4'hc;

  logic              clk;
  logic              rst_n;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [apb_aw-1:0] paddr;
  logic [apb_dw-1:0] pwdata;
  logic [apb_dw-1:0] prdata;
  logic              pready;
  logic              pslverr;

  calc_res_t         ref_q[$];   // Expected results in command order
  calc_res_t         exp_res;    // Head for the result read in progress
  logic [apb_dw-1:0] exp_word;
  logic              exp_empty;  // Result read should hit an empty FIFO
  logic              chk_status;
  logic [apb_dw-1:0] exp_status;
  int                pending;    // Accepted commands not yet read back
  int                cycles = 0;
  integer            seed   = 90;

  // Transfer completes at this edge
  logic done_w;
  logic rd_res;
  logic rd_st;
  logic wr_cmd_acc;
  assign done_w     = psel && penable && pready;
  assign rd_res     = done_w && !pwrite && (paddr == addr_result);
  assign rd_st      = done_w && !pwrite && (paddr == addr_status);
  assign wr_cmd_acc = psel && penable && pwrite && (paddr == addr_cmd); // Waits included
  assign exp_word   = {{(apb_dw - $bits(calc_res_t)){1'b0}}, exp_res};

  calc_top dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_test(input string what);
    $display("%s", what);
    $display("test failed");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      fail_test($sformatf("Timeout, run still going after %0d cycles", timeout_cycles));
    end
  end

  a_result_err : assert property (@(posedge clk) disable iff (!rst_n)
    rd_res && !exp_empty |-> !pslverr)
    else fail_test($sformatf("ERROR at %0t: pslverr got 1 expected 0", $time));
  a_result_data : assert property (@(posedge clk) disable iff (!rst_n)
    rd_res && !exp_empty |-> prdata == exp_word)
    else fail_test($sformatf("ERROR at %0t: prdata got 0x%h expected 0x%h",
                             $time, prdata, exp_word));
  a_empty_err : assert property (@(posedge clk) disable iff (!rst_n)
    rd_res && exp_empty |-> pslverr)
    else fail_test($sformatf("ERROR at %0t: pslverr got 0 expected 1", $time));
  a_empty_data : assert property (@(posedge clk) disable iff (!rst_n)
    rd_res && exp_empty |-> prdata == '0)
    else fail_test($sformatf("ERROR at %0t: prdata got 0x%h expected 0x0", $time, prdata));
  a_status : assert property (@(posedge clk) disable iff (!rst_n)
    rd_st && chk_status |-> prdata == exp_status)
    else fail_test($sformatf("ERROR at %0t: status got 0x%h expected 0x%h",
                             $time, prdata, exp_status));
  // Count bounded by depth and by what is outstanding
  a_count : assert property (@(posedge clk) disable iff (!rst_n)
    rd_st |-> int'(prdata[7:4]) <= fifo_depth && int'(prdata[7:4]) <= pending)
    else fail_test($sformatf("ERROR at %0t: status count got %0d expected at most %0d",
                             $time, prdata[7:4], (pending < fifo_depth) ? pending : fifo_depth));
  a_backpressure : assert property (@(posedge clk) disable iff (!rst_n)
    wr_cmd_acc && pending >= max_stored |-> !pready)
    else fail_test($sformatf("ERROR at %0t: pready got 1 expected 0", $time));
  a_write_ok : assert property (@(posedge clk) disable iff (!rst_n)
    done_w && pwrite && paddr == addr_cmd |-> !pslverr)
    else fail_test($sformatf("ERROR at %0t: pslverr got 1 expected 0", $time));
  a_write_err : assert property (@(posedge clk) disable iff (!rst_n)
    done_w && pwrite && paddr != addr_cmd |-> pslverr)
    else fail_test($sformatf("ERROR at %0t: pslverr got 0 expected 1", $time));
  a_idle : assert property (@(posedge clk) disable iff (!rst_n)
    !(psel && penable) |-> !pready && !pslverr)
    else fail_test($sformatf("ERROR at %0t: pready got %b expected 0", $time, pready));

  // Golden arithmetic in plain integers
  function automatic calc_res_t expected_result(calc_op_e op, logic [7:0] a, logic [7:0] b);
    int   x;
    int   y;
    int   r;
    logic ovf;
    x = int'(a);
    y = int'(b);
    case (op)
      op_add: begin
        r   = x + y;
        ovf = (r > 255);  // Carry
      end
      op_sub: begin
        ovf = (x < y);    // Borrow
        r   = ovf ? x - y + 256 : x - y;
      end
      op_mul: begin
        r   = x * y;
        ovf = (r > 255);
      end
      default: begin
        ovf = (y == 0);   // Divide by zero gives 0
        r   = ovf ? 0 : x / y;
      end
    endcase
    return '{overflow: ovf, result: r[7:0]};
  endfunction

  function automatic logic [apb_dw-1:0] status_word(int count, logic res_empty, logic cmd_full);
    logic [apb_dw-1:0] word;
    word      = '0;
    word[7:4] = 4'(count);
    word[1]   = res_empty;
    word[0]   = cmd_full;
    return word;
  endfunction

  // One APB transfer; gives up after max_wait stalled cycles and leaves the bus held
  task automatic apb_access(input logic wr, input logic [apb_aw-1:0] addr,
                            input logic [apb_dw-1:0] data, input int max_wait,
                            output logic [apb_dw-1:0] rdata, output logic done);
    int waited;
    waited = 0;
    @(posedge clk);
    psel    <= 1'b1; // Setup phase
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);  // Sample mid cycle
    while (!pready && waited < max_wait) begin
      @(negedge clk);
      waited++;
    end
    done  = pready;
    rdata = prdata;
    if (done) begin
      @(posedge clk); // Completion edge
      psel    <= 1'b0;
      penable <= 1'b0;
    end
  endtask

  task automatic write_cmd(input calc_op_e op, input logic [7:0] a, input logic [7:0] b);
    logic [apb_dw-1:0] rdata;
    logic              done;
    apb_access(1'b1, addr_cmd, {{(apb_dw - 18){1'b0}}, op, b, a}, timeout_cycles, rdata, done);
    ref_q.push_back(expected_result(op, a, b));
    pending <= ref_q.size();
  endtask

  task automatic write_bad(input logic [apb_aw-1:0] addr);
    logic [apb_dw-1:0] rdata;
    logic              done;
    apb_access(1'b1, addr, 32'h0001_0203, timeout_cycles, rdata, done);
  endtask

  // Poll status until one bit reaches a value
  task automatic wait_status(input int bit_idx, input logic val);
    logic [apb_dw-1:0] rdata;
    logic              done;
    do begin
      apb_access(1'b0, addr_status, '0, timeout_cycles, rdata, done);
    end while (rdata[bit_idx] != val);
  endtask

  task automatic check_status(input logic [apb_dw-1:0] expected);
    logic [apb_dw-1:0] rdata;
    logic              done;
    exp_status <= expected;
    chk_status <= 1'b1;
    apb_access(1'b0, addr_status, '0, timeout_cycles, rdata, done);
    chk_status <= 1'b0;
  endtask

  task automatic read_result();
    logic [apb_dw-1:0] rdata;
    logic              done;
    if (ref_q.size() == 0) begin
      exp_empty <= 1'b1;    // Nothing outstanding, error response
    end else begin
      wait_status(1, 1'b0); // Until a result is queued
      exp_empty <= 1'b0;
      exp_res   <= ref_q[0];
    end
    apb_access(1'b0, addr_result, '0, timeout_cycles, rdata, done);
    if (ref_q.size() > 0) begin
      ref_q.delete(0);
    end
    pending <= ref_q.size();
  endtask

  task automatic run_cmd(input calc_op_e op, input logic [7:0] a, input logic [7:0] b);
    write_cmd(op, a, b);
    read_result();
  endtask

  task automatic random_cmd();
    logic [31:0] r;
    r = $random(seed);
    write_cmd(calc_op_e'(r[17:16]), r[7:0], r[15:8]);
  endtask

  // Mid-run reset; bus held until the command FIFO is cleared
  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (2) @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    @(posedge clk);
    rst_n <= 1'b1;
    ref_q.delete();
    pending <= 0;
  endtask

  initial begin
    logic [31:0]       r;
    logic [apb_dw-1:0] rdata;
    logic              done;
    int                writes;
    rst_n      = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    exp_res    = '0;
    exp_empty  = 1'b0;
    chk_status = 1'b0;
    exp_status = '0;
    pending    = 0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    check_status(status_word(0, 1'b1, 1'b0));

    // Directed arithmetic, boundaries and divide by zero
    run_cmd(op_add, 8'hff, 8'h01);
    run_cmd(op_add, 8'h00, 8'h00);
    run_cmd(op_add, 8'hff, 8'hff);
    run_cmd(op_sub, 8'h05, 8'h03);
    run_cmd(op_sub, 8'h00, 8'h01); // Borrow
    run_cmd(op_sub, 8'hff, 8'hff);
    run_cmd(op_mul, 8'hff, 8'hff);
    run_cmd(op_mul, 8'h0f, 8'h11); // Exactly 255
    run_cmd(op_mul, 8'h00, 8'hff);
    run_cmd(op_div, 8'hff, 8'h05); // Exact
    run_cmd(op_div, 8'h64, 8'h07); // Remainder dropped
    run_cmd(op_div, 8'hff, 8'hff);
    run_cmd(op_div, 8'h00, 8'hff);
    run_cmd(op_div, 8'h12, 8'h00);

    // Error responses, then a normal result
    read_result();
    write_bad(addr_unmapped);
    write_bad(addr_status);
    run_cmd(op_add, 8'h7f, 8'h80);

    // Fill everything, drain in order
    repeat (max_stored) random_cmd();
    wait_status(0, 1'b1);
    check_status(status_word(fifo_depth, 1'b0, 1'b1));
    while (ref_q.size() > 0) read_result();
    check_status(status_word(0, 1'b1, 1'b0));

    // Fill again; one more write must stall until reset frees it
    repeat (max_stored) random_cmd();
    wait_status(0, 1'b1);
    check_status(status_word(fifo_depth, 1'b0, 1'b1));
    apb_access(1'b1, addr_cmd, 32'h0000_0101, stall_cycles, rdata, done);
    if (done) begin
      fail_test("Command write completed while the command FIFO was full");
    end
    apply_reset();
    check_status(status_word(0, 1'b1, 1'b0));

    // Random commands mixed with random reads
    writes = 0;
    while (writes < n_random) begin
      r = $random(seed);
      if (ref_q.size() >= max_stored || r[2:0] < 3'd3) begin
        read_result();
      end else begin
        write_cmd(calc_op_e'(r[17:16]), r[7:0], r[15:8]);
        writes++;
      end
    end
    while (ref_q.size() > 0) read_result();

    $display("test passed");
    $finish;
  end

endmodule
